// File: source/issue_pkg.sv
`default_nettype none

package issue_pkg;

    localparam int alu_queue_len     = 8;   // ALU issue queue depth
    localparam int alu_queue_idx_len = 3;   // Bits to address one entry

    typedef logic [5:0] prf_num_t;  // 64 physical registers
    typedef logic [4:0] rob_idx_t;  // Reorder buffer tag
    typedef logic [3:0] alu_op_t;

    typedef logic [alu_queue_idx_len-1:0] iq_idx_t;
    typedef logic [alu_queue_len-1:0]     queue_vec_t;  // One bit per entry, bit 0 oldest

    // Decoded ALU micro-op as it leaves dispatch
    typedef struct packed {
        rob_idx_t    rob_idx;
        alu_op_t     alu_op;
        prf_num_t    src0;
        prf_num_t    src1;
        prf_num_t    dst;
        logic        dstwe;     // Micro-op writes dst
        logic [31:0] imm;
    } uop_bundle_t;

    // One issue queue slot
    typedef struct packed {
        uop_bundle_t ops;
        logic        src0_rdy;
        logic        src1_rdy;
    } alu_queue_meta_t;

    // Two register broadcasts per cycle from the core
    typedef struct packed {
        logic     wake_en_0;
        prf_num_t wake_reg_0;
        logic     wake_en_1;
        prf_num_t wake_reg_1;
    } wake_info_t;

endpackage

`default_nettype wire

// File: source/iq_alu.sv
`timescale 1ns/1ps
`default_nettype none

module iq_alu (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         flush,
    // Dispatch side
    input  wire                         enq_req_0,
    input  wire                         enq_req_1,
    input  wire issue_pkg::alu_queue_meta_t din_0,
    input  wire issue_pkg::alu_queue_meta_t din_1,
    // Arbiter selection
    input  wire                         deq_req_0,
    input  wire                         deq_req_1,
    input  wire issue_pkg::iq_idx_t     deq0_idx,
    input  wire issue_pkg::iq_idx_t     deq1_idx,
    input  wire issue_pkg::wake_info_t  wake_info,
    output issue_pkg::queue_vec_t       ready_vec,
    output issue_pkg::queue_vec_t       valid_vec,
    output issue_pkg::alu_queue_meta_t  dout_0,
    output issue_pkg::alu_queue_meta_t  dout_1,
    output logic                        ready
);

    import issue_pkg::*;

    typedef logic [alu_queue_idx_len:0] cnt_t;  // Holds 0 to alu_queue_len

    alu_queue_meta_t q     [alu_queue_len];     // Slot 0 is the oldest
    alu_queue_meta_t q_nxt [alu_queue_len];
    alu_queue_meta_t woke  [alu_queue_len];     // Resident entries after wakeup
    alu_queue_meta_t din_0_woke;
    alu_queue_meta_t din_1_woke;

    queue_vec_t valid_q;
    queue_vec_t valid_nxt;
    queue_vec_t keep;       // Valid and not leaving this cycle
    cnt_t       count;
    cnt_t       count_nxt;

    // Marks a source ready when either broadcast names its register
    function automatic alu_queue_meta_t apply_wake(alu_queue_meta_t e, wake_info_t w);
        alu_queue_meta_t r;
        logic            hit0;
        logic            hit1;
        r    = e;
        hit0 = (w.wake_en_0 && w.wake_reg_0 == e.ops.src0) ||
               (w.wake_en_1 && w.wake_reg_1 == e.ops.src0);
        hit1 = (w.wake_en_0 && w.wake_reg_0 == e.ops.src1) ||
               (w.wake_en_1 && w.wake_reg_1 == e.ops.src1);
        if (hit0) begin
            r.src0_rdy = 1'b1;
        end
        if (hit1) begin
            r.src1_rdy = 1'b1;
        end
        return r;
    endfunction

    assign din_0_woke = apply_wake(din_0, wake_info);   // Same-cycle wake on entry
    assign din_1_woke = apply_wake(din_1, wake_info);

    always_comb begin
        for (int i = 0; i < alu_queue_len; i++) begin
            woke[i]      = apply_wake(q[i], wake_info);
            keep[i]      = valid_q[i] &&
                           !(deq_req_0 && deq0_idx == iq_idx_t'(i)) &&
                           !(deq_req_1 && deq1_idx == iq_idx_t'(i));
            ready_vec[i] = q[i].src0_rdy && q[i].src1_rdy;
        end
    end

    assign valid_vec = valid_q;
    assign dout_0    = q[deq0_idx];
    assign dout_1    = q[deq1_idx];

    // Collapse survivors toward slot 0, then append new micro-ops
    always_comb begin
        cnt_t ptr;
        ptr       = '0;
        valid_nxt = '0;
        for (int i = 0; i < alu_queue_len; i++) begin
            q_nxt[i] = q[i];
        end
        for (int i = 0; i < alu_queue_len; i++) begin
            if (keep[i]) begin
                q_nxt[ptr[alu_queue_idx_len-1:0]]     = woke[i];    // ptr never passes i
                valid_nxt[ptr[alu_queue_idx_len-1:0]] = 1'b1;
                ptr = ptr + cnt_t'(1);
            end
        end
        if (enq_req_0 && ptr < cnt_t'(alu_queue_len)) begin
            q_nxt[ptr[alu_queue_idx_len-1:0]]     = din_0_woke;
            valid_nxt[ptr[alu_queue_idx_len-1:0]] = 1'b1;
            ptr = ptr + cnt_t'(1);
        end
        // Lone slot 1 request lands in the lowest free slot
        if (enq_req_1 && ptr < cnt_t'(alu_queue_len)) begin
            q_nxt[ptr[alu_queue_idx_len-1:0]]     = din_1_woke;
            valid_nxt[ptr[alu_queue_idx_len-1:0]] = 1'b1;
            ptr = ptr + cnt_t'(1);
        end
        count_nxt = ptr;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            count   <= '0;
        end else if (flush) begin
            valid_q <= '0;      // Same-cycle enqueue is dropped
            count   <= '0;
        end else begin
            valid_q <= valid_nxt;
            count   <= count_nxt;
        end
    end

    always_ff @(posedge clk) begin
        q <= q_nxt;
    end

    // Dispatch needs room for a full pair
    assign ready = (count <= cnt_t'(alu_queue_len - 2));

    a_no_enq_when_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        (enq_req_0 || enq_req_1) |-> ready
    ) else $error("iq_alu: enqueue while ready is low");

    a_deq_order: assert property (
        @(posedge clk) disable iff (!rst_n)
        (deq_req_0 && deq_req_1) |-> (deq1_idx > deq0_idx)
    ) else $error("iq_alu: deq1_idx not above deq0_idx");

    a_deq_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        (deq_req_0 -> valid_q[deq0_idx]) && (deq_req_1 -> valid_q[deq1_idx])
    ) else $error("iq_alu: dequeue of an empty slot");

endmodule

`default_nettype wire

// File: source/issue_arbiter_8.sv
`timescale 1ns/1ps
`default_nettype none

module issue_arbiter_8 (
    input  wire issue_pkg::queue_vec_t rdys,    // Bit 0 is the oldest entry
    output issue_pkg::iq_idx_t         sel0,
    output issue_pkg::iq_idx_t         sel1,
    output logic                       sel0_valid,
    output logic                       sel1_valid
);

    import issue_pkg::*;

    queue_vec_t rdys_upper;     // Requests left after the first pick

    // Index of the lowest set bit, zero when none
    function automatic iq_idx_t lowest_set(queue_vec_t v);
        iq_idx_t idx;
        idx = '0;
        for (int i = alu_queue_len - 1; i >= 0; i--) begin
            if (v[i]) begin
                idx = iq_idx_t'(i);
            end
        end
        return idx;
    endfunction

    // First level takes the oldest ready entry
    assign sel0       = lowest_set(rdys);
    assign sel0_valid = |rdys;

    // Clearing the lowest set bit leaves only bits above sel0
    assign rdys_upper = rdys & (rdys - queue_vec_t'(1));

    assign sel1       = lowest_set(rdys_upper);
    assign sel1_valid = |rdys_upper;

    always_comb begin
        assert (!sel1_valid || sel0_valid)
            else $error("issue_arbiter_8: second grant without a first");
    end

endmodule

`default_nettype wire

// File: source/issue_alu.sv
`timescale 1ns/1ps
`default_nettype none

module issue_alu (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire                             flush,
    input  wire issue_pkg::wake_info_t      wake_info,     // Broadcasts from the core
    input  wire issue_pkg::alu_queue_meta_t inst_ops_0,
    input  wire issue_pkg::alu_queue_meta_t inst_ops_1,
    input  wire                             enq_req_0,
    input  wire                             enq_req_1,
    output issue_pkg::uop_bundle_t          issue_info_0,  // To ALU pipe 0
    output issue_pkg::uop_bundle_t          issue_info_1,  // To ALU pipe 1
    output logic                            issue_en_0,
    output logic                            issue_en_1,
    output issue_pkg::prf_num_t             wake_reg_0,
    output issue_pkg::prf_num_t             wake_reg_1,
    output logic                            wake_reg_0_en,
    output logic                            wake_reg_1_en,
    output logic                            ready
);

    import issue_pkg::*;

    queue_vec_t      ready_vec;
    queue_vec_t      valid_vec;
    queue_vec_t      arb_req;
    iq_idx_t         sel0;
    iq_idx_t         sel1;
    logic            sel0_valid;
    logic            sel1_valid;
    alu_queue_meta_t iq_dout_0;
    alu_queue_meta_t iq_dout_1;

    iq_alu u_iq_alu (
        .clk        (clk        ),
        .rst_n      (rst_n      ),
        .flush      (flush      ),
        .enq_req_0  (enq_req_0  ),
        .enq_req_1  (enq_req_1  ),
        .din_0      (inst_ops_0 ),
        .din_1      (inst_ops_1 ),
        .deq_req_0  (sel0_valid ),     // Selected entries leave at the edge
        .deq_req_1  (sel1_valid ),
        .deq0_idx   (sel0       ),
        .deq1_idx   (sel1       ),
        .wake_info  (wake_info  ),
        .ready_vec  (ready_vec  ),
        .valid_vec  (valid_vec  ),
        .dout_0     (iq_dout_0  ),
        .dout_1     (iq_dout_1  ),
        .ready      (ready      )
    );

    // Stale ready bits of empty slots must not request
    assign arb_req = ready_vec & valid_vec;

    issue_arbiter_8 u_issue_arbiter_8 (
        .rdys       (arb_req    ),
        .sel0       (sel0       ),
        .sel1       (sel1       ),
        .sel0_valid (sel0_valid ),
        .sel1_valid (sel1_valid )
    );

    assign issue_info_0  = iq_dout_0.ops;
    assign issue_info_1  = iq_dout_1.ops;
    assign issue_en_0    = sel0_valid;
    assign issue_en_1    = sel1_valid;

    assign wake_reg_0    = iq_dout_0.ops.dst;
    assign wake_reg_1    = iq_dout_1.ops.dst;
    assign wake_reg_0_en = sel0_valid && iq_dout_0.ops.dstwe;  // Only register writers wake
    assign wake_reg_1_en = sel1_valid && iq_dout_1.ops.dstwe;

    // Whatever the arbiter grants, the queue holds with both operands ready
    a_issue_operands_ready: assert property (
        @(posedge clk) disable iff (!rst_n)
        (issue_en_0 -> (iq_dout_0.src0_rdy && iq_dout_0.src1_rdy)) &&
        (issue_en_1 -> (iq_dout_1.src0_rdy && iq_dout_1.src1_rdy))
    ) else $error("issue_alu: issued micro-op with an unready source");

endmodule

`default_nettype wire

// File: test/tb_issue_alu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_issue_alu;

    import issue_pkg::*;

    localparam int stim_cycles    = 2000;
    localparam int timeout_cycles = stim_cycles + stim_cycles / 2;

    // Expected issue slots, with the model index each one came from
    typedef struct packed {
        logic        en_0;
        uop_bundle_t uop_0;
        iq_idx_t     idx_0;
        logic        en_1;
        uop_bundle_t uop_1;
        iq_idx_t     idx_1;
    } issue_pair_t;

    typedef alu_queue_meta_t meta_queue_t[$];

    logic            clk;
    logic            rst_n;
    logic            flush;
    wake_info_t      wake_info;
    alu_queue_meta_t inst_ops_0;
    alu_queue_meta_t inst_ops_1;
    logic            enq_req_0;
    logic            enq_req_1;
    uop_bundle_t     issue_info_0;
    uop_bundle_t     issue_info_1;
    logic            issue_en_0;
    logic            issue_en_1;
    prf_num_t        wake_reg_0;
    prf_num_t        wake_reg_1;
    logic            wake_reg_0_en;
    logic            wake_reg_1_en;
    logic            ready;

    alu_queue_meta_t model[$];  // Index 0 is the oldest
    logic [31:0]     rng;
    int              cycle_count;

    issue_alu uut (
        .clk          (clk          ),
        .rst_n        (rst_n        ),
        .flush        (flush        ),
        .wake_info    (wake_info    ),
        .inst_ops_0   (inst_ops_0   ),
        .inst_ops_1   (inst_ops_1   ),
        .enq_req_0    (enq_req_0    ),
        .enq_req_1    (enq_req_1    ),
        .issue_info_0 (issue_info_0 ),
        .issue_info_1 (issue_info_1 ),
        .issue_en_0   (issue_en_0   ),
        .issue_en_1   (issue_en_1   ),
        .wake_reg_0   (wake_reg_0   ),
        .wake_reg_1   (wake_reg_1   ),
        .wake_reg_0_en(wake_reg_0_en),
        .wake_reg_1_en(wake_reg_1_en),
        .ready        (ready        )
    );

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic step_random();
        rng = xorshift32(rng);
    endtask

    // Sources come from 16 registers so that wakeups hit often
    task automatic draw_meta(output alu_queue_meta_t m);
        step_random();
        m.ops.rob_idx = rng[4:0];
        m.ops.alu_op  = rng[8:5];
        m.ops.src0    = {2'b00, rng[12:9]};
        m.ops.src1    = {2'b00, rng[16:13]};
        m.src0_rdy    = rng[17] | rng[18];  // Ready three times in four
        m.src1_rdy    = rng[19] | rng[20];
        m.ops.dst     = rng[26:21];
        m.ops.dstwe   = rng[27] | rng[28];
        step_random();
        m.ops.imm     = rng;
    endtask

    task automatic draw_wake(output wake_info_t w);
        step_random();
        w.wake_en_0  = rng[0];
        w.wake_reg_0 = {2'b00, rng[4:1]};
        w.wake_en_1  = rng[5];
        w.wake_reg_1 = {2'b00, rng[9:6]};
    endtask

    function automatic logic names_reg(wake_info_t w, prf_num_t r);
        return (w.wake_en_0 && w.wake_reg_0 == r) || (w.wake_en_1 && w.wake_reg_1 == r);
    endfunction

    function automatic alu_queue_meta_t wake_entry(alu_queue_meta_t e, wake_info_t w);
        alu_queue_meta_t r;
        r          = e;
        r.src0_rdy = e.src0_rdy || names_reg(w, e.ops.src0);
        r.src1_rdy = e.src1_rdy || names_reg(w, e.ops.src1);
        return r;
    endfunction

    // Two oldest entries with both operands ready
    function automatic issue_pair_t expected_issue(meta_queue_t m);
        issue_pair_t p;
        int          found;
        p     = '0;
        found = 0;
        for (int i = 0; i < m.size(); i++) begin
            if (m[i].src0_rdy && m[i].src1_rdy) begin
                if (found == 0) begin
                    p.en_0  = 1'b1;
                    p.uop_0 = m[i].ops;
                    p.idx_0 = iq_idx_t'(i);
                end else if (found == 1) begin
                    p.en_1  = 1'b1;
                    p.uop_1 = m[i].ops;
                    p.idx_1 = iq_idx_t'(i);
                end
                found++;
            end
        end
        return p;
    endfunction

    // Next queue state from this cycle's inputs and issue
    task automatic update_model(issue_pair_t p);
        alu_queue_meta_t kept[$];
        if (flush) begin
            model.delete();     // Enqueue in a flush cycle is lost
        end else begin
            for (int i = 0; i < model.size(); i++) begin
                if (!(p.en_0 && p.idx_0 == iq_idx_t'(i)) &&
                    !(p.en_1 && p.idx_1 == iq_idx_t'(i))) begin
                    kept.push_back(wake_entry(model[i], wake_info));
                end
            end
            if (enq_req_0) begin
                kept.push_back(wake_entry(inst_ops_0, wake_info));
            end
            if (enq_req_1) begin
                kept.push_back(wake_entry(inst_ops_1, wake_info));
            end
            model = kept;
        end
    endtask

    task automatic report_mismatch(string what);
        $display("ERROR at %0t ns: %s", $time, what);
        $display("Finished with errors");
        $fatal(1, "Stopping at the first mismatch");
    endtask

    task automatic check_issue(string name, uop_bundle_t got, logic got_en,
                               uop_bundle_t want, logic want_en);
        if (got_en !== want_en) begin
            report_mismatch($sformatf("%s enable is %b, expected %b", name, got_en, want_en));
        end else if (want_en && got !== want) begin
            report_mismatch($sformatf("%s micro-op is %h, expected %h", name, got, want));
        end
    endtask

    task automatic check_wake(string name, prf_num_t got, logic got_en,
                              prf_num_t want, logic want_en);
        if (got_en !== want_en) begin
            report_mismatch($sformatf("%s enable is %b, expected %b", name, got_en, want_en));
        end else if (want_en && got !== want) begin
            report_mismatch($sformatf("%s register is %0d, expected %0d", name, got, want));
        end
    endtask

    task automatic check_ready(logic got, logic want);
        if (got !== want) begin
            report_mismatch($sformatf("ready is %b, expected %b with %0d entries",
                                      got, want, model.size()));
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        alu_queue_meta_t m0;
        alu_queue_meta_t m1;
        wake_info_t      w;
        logic            can_enq;
        rng        = 32'hf1ba4bd5;
        rst_n      <= 1'b0;
        flush      <= 1'b0;
        wake_info  <= '0;
        inst_ops_0 <= '0;
        inst_ops_1 <= '0;
        enq_req_0  <= 1'b0;
        enq_req_1  <= 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        repeat (stim_cycles) begin
            @(posedge clk);
            draw_meta(m0);
            draw_meta(m1);
            draw_wake(w);
            step_random();
            can_enq    = model.size() <= alu_queue_len - 2;   // Model holds the coming cycle
            flush      <= (rng[5:0] == 6'd0);
            enq_req_0  <= can_enq && (rng[7:6] != 2'b00);
            enq_req_1  <= can_enq && (rng[9:8] != 2'b00);
            inst_ops_0 <= m0;
            inst_ops_1 <= m1;
            wake_info  <= w;
        end
        @(posedge clk);
        flush     <= 1'b0;
        enq_req_0 <= 1'b0;
        enq_req_1 <= 1'b0;
        @(posedge clk);
        $display("Finished with no errors");
        $finish;
    end

    // Outputs are settled at the falling edge
    initial begin
        issue_pair_t expected;
        forever begin
            @(negedge clk);
            expected = expected_issue(model);
            check_issue("issue slot 0", issue_info_0, issue_en_0, expected.uop_0, expected.en_0);
            check_issue("issue slot 1", issue_info_1, issue_en_1, expected.uop_1, expected.en_1);
            check_wake("wake slot 0", wake_reg_0, wake_reg_0_en, expected.uop_0.dst,
                       expected.en_0 && expected.uop_0.dstwe);
            check_wake("wake slot 1", wake_reg_1, wake_reg_1_en, expected.uop_1.dst,
                       expected.en_1 && expected.uop_1.dstwe);
            check_ready(ready, model.size() <= alu_queue_len - 2);
            if (rst_n) begin
                update_model(expected);
            end
        end
    end

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count >= timeout_cycles) begin
                $display("Test did not finish within %0d cycles", timeout_cycles);
                $display("Finished with errors");
                $fatal(1, "Timeout");
            end
        end
    end

endmodule

`default_nettype wire

// File: all.f
source/issue_pkg.sv
source/iq_alu.sv
source/issue_arbiter_8.sv
source/issue_alu.sv
test/tb_issue_alu.sv

// File: Makefile
TB_TOP := tb_issue_alu

.PHONY: all lint clean

all:
	verilator --binary --timing -Wall -f all.f --top-module $(TB_TOP) -o $(TB_TOP)
	@out="$$(./obj_dir/$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Finished with no errors"

lint:
	verilator --lint-only -Wall \
		source/issue_pkg.sv \
		source/iq_alu.sv \
		source/issue_arbiter_8.sv \
		source/issue_alu.sv \
		--top-module issue_alu

clean:
	rm -rf obj_dir
